// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_arithmetic_encoder
FILELIST  := all.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJDIR)
LINTFLAGS := --lint-only --timing -Wall --top-module $(TOP)
PASS_MSG  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== all.f ====
src/ec_const_pkg.sv
src/ec_pipe_pkg.sv
src/ec_control.sv
src/ec_split_stage.sv
src/ec_range_stage.sv
src/ec_low_stage.sv
src/arithmetic_encoder.sv
dv/tb_arithmetic_encoder.sv

// ==== dv/tb_arithmetic_encoder.sv ====
`timescale 1ns/1ps

module tb_arithmetic_encoder;

    localparam int SYMBOL_WIDTH = 4;
    localparam int LOW_WIDTH    = 24;
    localparam int RW           = ec_const_pkg::RANGE_WIDTH;
    localparam int INIT         = ec_const_pkg::INIT_RANGE;

    localparam int RESET_CYCLES    = 16;
    localparam int DRAIN_CYCLES    = 4;
    localparam int N_MULTI         = 200;
    localparam int N_FIRST         = 50;
    localparam int N_BOOL          = 150;
    localparam int N_MIXED         = 400;
    localparam int N_TESTS         = 4;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_MULTI + N_FIRST + N_BOOL + N_MIXED
                                     + N_TESTS * (DRAIN_CYCLES + 1) + 50;

    localparam int KIND_MULTI = 0;
    localparam int KIND_FIRST = 1;
    localparam int KIND_BOOL  = 2;
    localparam int KIND_MIXED = 3;

    localparam longint unsigned LOW_MASK = (64'd1 << LOW_WIDTH) - 64'd1;

    logic                    general_clk;
    logic                    reset;
    logic [RW-1:0]           general_fl;
    logic [RW-1:0]           general_fh;
    logic [SYMBOL_WIDTH-1:0] general_symbol;
    logic [SYMBOL_WIDTH:0]   general_nsyms;
    logic                    general_bool;
    logic [RW-1:0]           range_out;
    logic [LOW_WIDTH-1:0]    low_out;

    arithmetic_encoder #(
        .SYMBOL_WIDTH (SYMBOL_WIDTH),
        .LOW_WIDTH    (LOW_WIDTH)
    ) dut (
        .general_clk    (general_clk),
        .reset          (reset),
        .general_fl     (general_fl),
        .general_fh     (general_fh),
        .general_symbol (general_symbol),
        .general_nsyms  (general_nsyms),
        .general_bool   (general_bool),
        .range_out      (range_out),
        .low_out        (low_out)
    );

    integer seed;
    int     error_count;
    int     check_count;
    int     wrap_count;
    int     test_count;

    // reference model state
    int unsigned     ref_range;
    longint unsigned ref_low;

    // expected outputs, slot 2 lines up with the DUT outputs
    logic [2:0]           exp_valid;
    logic [RW-1:0]        exp_range [3];
    logic [LOW_WIDTH-1:0] exp_low [3];
    logic                 reset_seen;
    int                   edges_since_reset;

    initial begin
        general_clk = 1'b0;
        forever #20 general_clk = ~general_clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % 32'(n));
    endfunction

    function automatic int top_bit(input int unsigned value);
        int idx;
        idx = 0;
        while ((value >> (idx + 1)) != 0) begin
            idx++;
        end
        return idx;
    endfunction

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------

    task automatic model_step(input int unsigned fl, input int unsigned fh,
                              input int unsigned sym, input int unsigned n,
                              input logic is_bool);
        int unsigned     r;
        int unsigned     rs;
        int unsigned     u;
        int unsigned     v;
        int unsigned     new_r;
        int unsigned     gain;
        int              d;
        longint unsigned wide;
        r    = ref_range;
        rs   = r >> ec_const_pkg::RANGE_SHIFT;
        gain = 0;
        if (is_bool) begin
            v = ((rs * (fh >> ec_const_pkg::PROB_SHIFT)) >> 1) + ec_const_pkg::MIN_PROB;
            if ((sym & 1) != 0) begin
                gain  = r - v;
                new_r = v;
            end else begin
                new_r = r - v;
            end
        end else begin
            v = ((rs * (fh >> ec_const_pkg::PROB_SHIFT)) >> 1)
                + ec_const_pkg::MIN_PROB * (n - 1 - sym);
            if (fl < INIT) begin
                u = ((rs * (fl >> ec_const_pkg::PROB_SHIFT)) >> 1)
                    + ec_const_pkg::MIN_PROB * (n - sym);
                new_r = u - v;
                gain  = r - u;
            end else begin
                new_r = r - v;
            end
        end
        d    = RW - 1 - top_bit(new_r);
        wide = (ref_low + 64'(gain)) << d;
        // bits above LOW_WIDTH get dropped
        if ((wide & ~LOW_MASK) != 0) begin
            wrap_count++;
        end
        ref_low   = wide & LOW_MASK;
        ref_range = new_r << d;
    endtask

    always @(posedge general_clk) begin
        if (reset) begin
            ref_range = INIT;
            ref_low   = 0;
            reset_seen        <= 1'b1;
            edges_since_reset <= 0;
        end else begin
            model_step(32'(general_fl), 32'(general_fh), 32'(general_symbol),
                       32'(general_nsyms), general_bool);
            if (edges_since_reset < 15) begin
                edges_since_reset <= edges_since_reset + 1;
            end
        end
        if (exp_valid[2]) begin
            check_count <= check_count + 1;
        end
        exp_valid    <= {exp_valid[1:0], 1'b1};
        exp_range[2] <= exp_range[1];
        exp_range[1] <= exp_range[0];
        exp_range[0] <= RW'(ref_range);
        exp_low[2]   <= exp_low[1];
        exp_low[1]   <= exp_low[0];
        exp_low[0]   <= LOW_WIDTH'(ref_low);
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    a_reset_range : assert property (@(posedge general_clk)
        (reset_seen && edges_since_reset <= 2) |-> range_out == RW'(INIT))
    else begin
        $display("FAILED t=%0t range_out expected %h got %h",
                 $time, RW'(INIT), $sampled(range_out));
        error_count++;
    end

    a_reset_low : assert property (@(posedge general_clk)
        (reset_seen && edges_since_reset <= 2) |-> low_out == '0)
    else begin
        $display("FAILED t=%0t low_out expected %h got %h", $time, 0, $sampled(low_out));
        error_count++;
    end

    a_range_match : assert property (@(posedge general_clk)
        exp_valid[2] |-> range_out == exp_range[2])
    else begin
        $display("FAILED t=%0t range_out expected %h got %h",
                 $time, $sampled(exp_range[2]), $sampled(range_out));
        error_count++;
    end

    a_low_match : assert property (@(posedge general_clk)
        exp_valid[2] |-> low_out == exp_low[2])
    else begin
        $display("FAILED t=%0t low_out expected %h got %h",
                 $time, $sampled(exp_low[2]), $sampled(low_out));
        error_count++;
    end

    // normalized range, 16 bits wide so the top is 65535
    a_range_bound : assert property (@(posedge general_clk)
        reset_seen |-> range_out >= RW'(INIT))
    else begin
        $display("FAILED t=%0t range_out expected >= %h got %h",
                 $time, RW'(INIT), $sampled(range_out));
        error_count++;
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------

    task automatic apply_symbol(input int fl, input int fh, input int sym, input int n,
                                input logic is_bool);
        @(posedge general_clk);
        general_fl     <= RW'(fl);
        general_fh     <= RW'(fh);
        general_symbol <= SYMBOL_WIDTH'(sym);
        general_nsyms  <= (SYMBOL_WIDTH + 1)'(n);
        general_bool   <= is_bool;
    endtask

    task automatic send_multi(input logic first_only);
        int n;
        int sym;
        int fl;
        int fh;
        n   = 2 + rand_below(15);
        sym = first_only ? 0 : rand_below(n);
        // last symbol of the alphabet ends the cdf at zero
        fh  = (sym == n - 1) ? 0 : rand_below(INIT - 4 * n);
        if (sym == 0) begin
            fl = INIT;
        end else begin
            fl = fh + 4 * n + rand_below(INIT - fh - 4 * n);
        end
        apply_symbol(fl, fh, sym, n, 1'b0);
    endtask

    task automatic send_bool();
        int f;
        int b;
        f = 1 + rand_below(INIT - 1);
        b = rand_below(2);
        apply_symbol(INIT, f, b, 2, 1'b1);
    endtask

    task automatic run_test(input string name, input int kind, input int count);
        int errors_before;
        int wraps_before;
        errors_before = error_count;
        wraps_before  = wrap_count;
        for (int i = 0; i < count; i++) begin
            case (kind)
                KIND_MULTI: send_multi(1'b0);
                KIND_FIRST: send_multi(1'b1);
                KIND_BOOL:  send_bool();
                default: begin
                    if (rand_below(2) == 0) begin
                        send_bool();
                    end else begin
                        send_multi(1'b0);
                    end
                end
            endcase
        end
        // let the last symbol reach its check
        repeat (DRAIN_CYCLES) @(posedge general_clk);
        @(negedge general_clk);
        if (kind == KIND_MIXED && wrap_count == wraps_before) begin
            $display("low never grew past %0d bits during the mixed stream", LOW_WIDTH);
            error_count++;
        end
        test_count++;
        $display("test %s: %0d symbols, %0d errors", name, count, error_count - errors_before);
    endtask

    initial begin
        seed              = 32'hc38cb54e;
        error_count       = 0;
        check_count       = 0;
        wrap_count        = 0;
        test_count        = 0;
        ref_range         = INIT;
        ref_low           = 0;
        exp_valid         = 3'b000;
        reset_seen        = 1'b0;
        edges_since_reset = 0;
        reset             = 1'b1;
        general_fl        = RW'(INIT);
        general_fh        = '0;
        general_symbol    = '0;
        general_nsyms     = (SYMBOL_WIDTH + 1)'(2);
        general_bool      = 1'b0;
        repeat (RESET_CYCLES) @(posedge general_clk);
        reset <= 1'b0;
        run_test("multi_symbol", KIND_MULTI, N_MULTI);
        run_test("first_symbol", KIND_FIRST, N_FIRST);
        run_test("bool", KIND_BOOL, N_BOOL);
        run_test("mixed_long", KIND_MIXED, N_MIXED);
        $display("summary: %0d tests, %0d cycles checked, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge general_clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== src/arithmetic_encoder.sv ====
`timescale 1ns/1ps

module arithmetic_encoder #(
    parameter int SYMBOL_WIDTH = 4,
    parameter int LOW_WIDTH    = 24
) (
    input  logic                                 general_clk,
    input  logic                                 reset,
    input  logic [ec_const_pkg::RANGE_WIDTH-1:0] general_fl,
    input  logic [ec_const_pkg::RANGE_WIDTH-1:0] general_fh,
    input  logic [SYMBOL_WIDTH-1:0]              general_symbol,
    input  logic [SYMBOL_WIDTH:0]                general_nsyms,
    input  logic                                 general_bool,
    output logic [ec_const_pkg::RANGE_WIDTH-1:0] range_out,
    output logic [LOW_WIDTH-1:0]                 low_out
);

    localparam int RW = ec_const_pkg::RANGE_WIDTH;
    localparam int DW = ec_const_pkg::D_WIDTH;

    logic en_1_2;
    logic en_2_3;
    logic en_final;

    ec_control u_control (
        .general_clk (general_clk),
        .reset       (reset),
        .en_1_2      (en_1_2),
        .en_2_3      (en_2_3),
        .en_final    (en_final)
    );

    // ------------------------------------------------------------------
    // stage 1
    // ------------------------------------------------------------------

    ec_pipe_pkg::split_t split_d;
    ec_pipe_pkg::split_t split_q;

    ec_split_stage #(
        .SYMBOL_WIDTH (SYMBOL_WIDTH)
    ) u_split (
        .fl      (general_fl),
        .fh      (general_fh),
        .symbol  (general_symbol),
        .nsyms   (general_nsyms),
        .is_bool (general_bool),
        .split   (split_d)
    );

    always_ff @(posedge general_clk) begin
        if (en_1_2) begin
            split_q <= split_d;
        end
    end

    // ------------------------------------------------------------------
    // stage 2, range feeds back into itself
    // ------------------------------------------------------------------

    ec_pipe_pkg::range_t range_rec_d;
    ec_pipe_pkg::range_t range_rec_q;
    logic [RW-1:0]       range_next;
    logic [RW-1:0]       range_q;

    ec_range_stage u_range (
        .split      (split_q),
        .cur_range  (range_q),
        .rec        (range_rec_d),
        .next_range (range_next)
    );

    always_ff @(posedge general_clk) begin
        if (en_2_3) begin
            range_rec_q <= range_rec_d;
        end
    end

    always_ff @(posedge general_clk) begin
        if (reset) begin
            range_q <= RW'(ec_const_pkg::INIT_RANGE);
        end else if (en_2_3) begin
            range_q <= range_next;
        end
    end

    // ------------------------------------------------------------------
    // stage 3
    // ------------------------------------------------------------------

    logic [LOW_WIDTH-1:0] low_next;
    logic [LOW_WIDTH-1:0] low_q;
    logic [DW-1:0]        s_next;
    logic [DW-1:0]        s_q;
    logic [RW-1:0]        range_final_q;

    ec_low_stage #(
        .LOW_WIDTH (LOW_WIDTH)
    ) u_low (
        .rec      (range_rec_q),
        .cur_low  (low_q),
        .cur_s    (s_q),
        .next_low (low_next),
        .next_s   (s_next)
    );

    // range copy keeps range_out in step with low
    always_ff @(posedge general_clk) begin
        if (reset) begin
            low_q         <= '0;
            s_q           <= '0;
            range_final_q <= RW'(ec_const_pkg::INIT_RANGE);
        end else if (en_final) begin
            low_q         <= low_next;
            s_q           <= s_next;
            range_final_q <= range_q;
        end
    end

    assign range_out = range_final_q;
    assign low_out   = low_q;

    // normalized range seen at the output once the pipe is full
    a_range_normalized : assert property (
        @(posedge general_clk) disable iff (reset)
            en_final |-> range_out >= RW'(ec_const_pkg::INIT_RANGE)
    ) else $error("range_out %0d below normalization bound", range_out);

endmodule

// ==== src/ec_const_pkg.sv ====
package ec_const_pkg;

    // ------------------------------------------------------------------
    // coder arithmetic
    // ------------------------------------------------------------------

    // range register and its value after reset
    localparam int RANGE_WIDTH = 16;
    localparam int INIT_RANGE  = 32768;

    // fl, fh and f lose their low bits before the multiply
    localparam int PROB_SHIFT  = 6;

    // only the top bits of the range enter the multiply
    localparam int RANGE_SHIFT = 8;

    // minimum probability per remaining symbol
    localparam int MIN_PROB    = 4;

    // normalization shift d and the shift counter s
    localparam int D_WIDTH     = 5;

    // derived widths
    localparam int PQ_WIDTH    = RANGE_WIDTH - PROB_SHIFT;
    localparam int RS_WIDTH    = RANGE_WIDTH - RANGE_SHIFT;
    localparam int PROD_WIDTH  = PQ_WIDTH + RS_WIDTH;

    // u and v carry one bit above the range
    localparam int UV_WIDTH    = RANGE_WIDTH + 1;

endpackage

// ==== src/ec_control.sv ====
`timescale 1ns/1ps

module ec_control (
    input  logic general_clk,
    input  logic reset,
    output logic en_1_2,
    output logic en_2_3,
    output logic en_final
);

    // number of stages holding a real symbol, stops at 2
    logic [1:0] fill_cnt;

    always_ff @(posedge general_clk) begin
        if (reset) begin
            fill_cnt <= 2'd0;
        end else if (!fill_cnt[1]) begin
            fill_cnt <= fill_cnt + 2'd1;
        end
    end

    // stage 1 opens as soon as reset drops
    assign en_1_2   = ~reset;
    assign en_2_3   = (fill_cnt != 2'd0);
    assign en_final = fill_cnt[1];

    // ------------------------------------------------------------------
    // enable ordering
    // ------------------------------------------------------------------

    // a later stage only opens once the one before it held data
    a_final_after_2_3 : assert property (
        @(posedge general_clk) disable iff (reset)
            en_final |-> $past(en_2_3)
    ) else $error("en_final set before en_2_3");

endmodule

// ==== src/ec_low_stage.sv ====
`timescale 1ns/1ps

module ec_low_stage #(
    parameter int LOW_WIDTH = 24
) (
    input  ec_pipe_pkg::range_t              rec,
    input  logic [LOW_WIDTH-1:0]             cur_low,
    input  logic [ec_const_pkg::D_WIDTH-1:0] cur_s,
    output logic [LOW_WIDTH-1:0]             next_low,
    output logic [ec_const_pkg::D_WIDTH-1:0] next_s
);

    localparam int UVW = ec_const_pkg::UV_WIDTH;

    // ------------------------------------------------------------------
    // low update
    // ------------------------------------------------------------------

    logic [UVW-1:0]       low_gain;
    logic [LOW_WIDTH-1:0] low_add;
    logic [LOW_WIDTH-1:0] low_sum;

    // part of the range below the split point
    assign low_gain = UVW'(rec.start_range) - rec.u;
    assign low_add  = rec.add_low ? LOW_WIDTH'(low_gain) : '0;

    // carry out of the top is lost
    assign low_sum  = cur_low + low_add;

    // shifted-out bits drop off, no byte output
    assign next_low = low_sum << rec.d;

    // ------------------------------------------------------------------
    // shift counter
    // ------------------------------------------------------------------

    // wraps at D_WIDTH
    assign next_s = cur_s + rec.d;

endmodule

// ==== src/ec_pipe_pkg.sv ====
package ec_pipe_pkg;

    // ------------------------------------------------------------------
    // stage 1 -> stage 2
    // ------------------------------------------------------------------

    typedef struct packed {
        // scaled cdf bounds
        logic [ec_const_pkg::PQ_WIDTH-1:0]    fl_q;
        // holds f in bool mode
        logic [ec_const_pkg::PQ_WIDTH-1:0]    fh_q;
        // MIN_PROB weighted symbol offsets
        logic [ec_const_pkg::RANGE_WIDTH-1:0] off_u;
        logic [ec_const_pkg::RANGE_WIDTH-1:0] off_v;
        // fl below 32768, so u is formed
        logic                                 use_fl;
        logic                                 is_bool;
        logic                                 bit_val;
    } split_t;

    // ------------------------------------------------------------------
    // stage 2 -> stage 3
    // ------------------------------------------------------------------

    typedef struct packed {
        // range before this symbol
        logic [ec_const_pkg::RANGE_WIDTH-1:0] start_range;
        // u in multi-symbol mode, v for a bool one
        logic [ec_const_pkg::UV_WIDTH-1:0]    u;
        // normalization shift
        logic [ec_const_pkg::D_WIDTH-1:0]     d;
        // low gains start_range - u
        logic                                 add_low;
    } range_t;

endpackage

// ==== src/ec_range_stage.sv ====
`timescale 1ns/1ps

module ec_range_stage (
    input  ec_pipe_pkg::split_t                  split,
    input  logic [ec_const_pkg::RANGE_WIDTH-1:0] cur_range,
    output ec_pipe_pkg::range_t                  rec,
    output logic [ec_const_pkg::RANGE_WIDTH-1:0] next_range
);

    localparam int UVW = ec_const_pkg::UV_WIDTH;
    localparam int RW  = ec_const_pkg::RANGE_WIDTH;

    // returns 15 minus the top set bit of r
    function automatic logic [ec_const_pkg::D_WIDTH-1:0] norm_shift(
        input logic [ec_const_pkg::RANGE_WIDTH-1:0] r
    );
        logic [ec_const_pkg::D_WIDTH-1:0] top;
        top = '0;
        for (int i = 0; i < ec_const_pkg::RANGE_WIDTH; i++) begin
            if (r[i]) begin
                top = ec_const_pkg::D_WIDTH'(i);
            end
        end
        return ec_const_pkg::D_WIDTH'(ec_const_pkg::RANGE_WIDTH - 1) - top;
    endfunction

    // ------------------------------------------------------------------
    // split points
    // ------------------------------------------------------------------

    logic [ec_const_pkg::RS_WIDTH-1:0]   rs;
    logic [ec_const_pkg::PROD_WIDTH-1:0] prod_u;
    logic [ec_const_pkg::PROD_WIDTH-1:0] prod_v;
    logic [UVW-1:0]                      u_full;
    logic [UVW-1:0]                      v_full;
    logic [UVW-1:0]                      v_off;

    assign rs     = ec_const_pkg::RS_WIDTH'(cur_range >> ec_const_pkg::RANGE_SHIFT);
    assign prod_u = rs * split.fl_q;
    assign prod_v = rs * split.fh_q;

    // bool symbols get the flat minimum instead of the rom offset
    assign v_off  = split.is_bool ? UVW'(ec_const_pkg::MIN_PROB) : UVW'(split.off_v);

    assign u_full = UVW'(prod_u >> 1) + UVW'(split.off_u);
    assign v_full = UVW'(prod_v >> 1) + v_off;

    // ------------------------------------------------------------------
    // new range and normalization
    // ------------------------------------------------------------------

    logic [UVW-1:0] new_full;
    logic [RW-1:0]  new_range;

    always_comb begin
        if (split.is_bool) begin
            new_full = split.bit_val ? v_full : UVW'(cur_range) - v_full;
        end else if (split.use_fl) begin
            new_full = u_full - v_full;
        end else begin
            new_full = UVW'(cur_range) - v_full;
        end
    end

    assign new_range = RW'(new_full);

    always_comb begin
        rec.start_range = cur_range;
        // bool mode carries v in the u slot
        rec.u           = split.is_bool ? v_full : u_full;
        rec.d           = norm_shift(new_range);
        rec.add_low     = split.is_bool ? split.bit_val : split.use_fl;
        next_range      = new_range << rec.d;
    end

    // offsets from stage 1 keep the interval non-empty
    always_comb begin
        if (split.use_fl) begin
            a_u_above_v : assert (u_full > v_full)
                else $error("u %0d not above v %0d", u_full, v_full);
        end
    end

endmodule

// ==== src/ec_split_stage.sv ====
`timescale 1ns/1ps

module ec_split_stage #(
    parameter int SYMBOL_WIDTH = 4
) (
    input  logic [ec_const_pkg::RANGE_WIDTH-1:0] fl,
    input  logic [ec_const_pkg::RANGE_WIDTH-1:0] fh,
    input  logic [SYMBOL_WIDTH-1:0]              symbol,
    input  logic [SYMBOL_WIDTH:0]                nsyms,
    input  logic                                 is_bool,
    output ec_pipe_pkg::split_t                  split
);

    localparam int CNT_WIDTH = SYMBOL_WIDTH + 1;
    localparam int ROM_DEPTH = 2 ** CNT_WIDTH;

    // ------------------------------------------------------------------
    // offset rom
    // ------------------------------------------------------------------

    // entry n holds MIN_PROB * n
    logic [ec_const_pkg::RANGE_WIDTH-1:0] offset_rom [ROM_DEPTH];

    always_comb begin
        for (int i = 0; i < ROM_DEPTH; i++) begin
            offset_rom[i] = ec_const_pkg::RANGE_WIDTH'(i * ec_const_pkg::MIN_PROB);
        end
    end

    // symbols left above and at the current one
    logic [CNT_WIDTH-1:0] cnt_u;
    logic [CNT_WIDTH-1:0] cnt_v;

    assign cnt_u = nsyms - {1'b0, symbol};
    assign cnt_v = cnt_u - CNT_WIDTH'(1);

    // ------------------------------------------------------------------
    // record
    // ------------------------------------------------------------------

    always_comb begin
        split.fl_q    = ec_const_pkg::PQ_WIDTH'(fl >> ec_const_pkg::PROB_SHIFT);
        // fh doubles as the bool probability
        split.fh_q    = ec_const_pkg::PQ_WIDTH'(fh >> ec_const_pkg::PROB_SHIFT);
        split.off_u   = offset_rom[cnt_u];
        split.off_v   = offset_rom[cnt_v];

        // fl of 32768 marks the first symbol of the alphabet
        split.use_fl  = ~fl[ec_const_pkg::RANGE_WIDTH-1] & ~is_bool;
        split.is_bool = is_bool;
        split.bit_val = symbol[0];
    end

endmodule
